/* Bender.yml */
package:
  name: dma_ch

sources:
  - files:
      - dma_ch_pkg.sv
      - ch_fifo.sv
      - ch_decode.sv
      - ch_execute.sv
      - ch_result.sv
      - dma_ch.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_dma_ch.sv

/* ch_decode.sv */
//******************************
// channel decode
// four-phase descriptor handshake and the
// job state machine feeding execute
//******************************
`timescale 1ns/10ps

module ch_decode (
   input  logic                 wb_clk_i,
   input  logic                 arst_n_i,
   input  logic                 clear_i,
   input  dma_ch_pkg::ch_desc_t dc_i,
   input  logic                 dc_req_i,
   output logic                 dc_ack_o,
   input  logic                 job_done_i,
   output dma_ch_pkg::ch_job_t  job_o,
   output logic                 run_o
);
   import dma_ch_pkg::*;

   dec_state_e state;
   dec_state_e state_nxt;
   ch_job_t    job_q;
   logic       start;

   // a new request is only taken while idle
   assign start = (state == ST_IDLE) && dc_req_i;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (dc_req_i) begin
               state_nxt = ST_RUN;
            end
         end
         ST_RUN: begin
            // result reports the push of the last word
            if (job_done_i) begin
               state_nxt = ST_ACK;
            end
         end
         ST_ACK: begin
            if (!dc_req_i) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= ST_IDLE;
      end else if (clear_i) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // reserved descriptor bits are dropped here
   always_ff @(posedge wb_clk_i) begin
      if (start) begin
         job_q.op  <= dc_i.op;
         job_q.key <= dc_i.key;
      end
   end

   assign job_o    = job_q;
   assign run_o    = (state == ST_RUN);
   assign dc_ack_o = (state == ST_ACK);

endmodule

/* ch_execute.sv */
//******************************
// channel execute
// pops the source FIFO during a job and applies
// the word operation into one pipeline register
//******************************
`timescale 1ns/10ps

module ch_execute (
   input  logic                  wb_clk_i,
   input  logic                  arst_n_i,
   input  logic                  clear_i,
   input  logic                  run_i,
   input  dma_ch_pkg::ch_job_t   job_i,
   input  dma_ch_pkg::ch_entry_t src_entry_i,
   input  logic                  src_empty_i,
   output logic                  src_pop_o,
   input  logic                  ex_ready_i,
   output logic                  ex_valid_o,
   output dma_ch_pkg::ch_entry_t ex_entry_o
);
   import dma_ch_pkg::*;

   ch_entry_t ex_entry_q;
   logic      ex_valid_q;
   logic      last_taken;
   logic      reg_free;

   // word transform for one job
   function automatic ch_word_t apply_op(input ch_job_t job, input ch_word_t w);
      ch_word_t res;
      res = w;
      case (job.op)
         OP_SWAP: begin
            for (int i = 0; i < 8; i++) begin
               res[8*i +: 8] = w[56-8*i +: 8];
            end
         end
         OP_XOR: begin
            res = w ^ {4{job.key}};
         end
         OP_ADD: begin
            // each 16-bit lane wraps on its own, no carry between lanes
            for (int i = 0; i < 4; i++) begin
               res[16*i +: 16] = w[16*i +: 16] + job.key;
            end
         end
         default: begin
            res = w;
         end
      endcase
      return res;
   endfunction

   // the register can take a new word if it is empty or being drained
   assign reg_free = !ex_valid_q || ex_ready_i;

   // no pop past the last word of the job, the next job waits for run_i
   assign src_pop_o = run_i && !src_empty_i && !last_taken && reg_free;

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ex_valid_q <= 1'b0;
         last_taken <= 1'b0;
      end else if (clear_i) begin
         ex_valid_q <= 1'b0;
         last_taken <= 1'b0;
      end else begin
         if (src_pop_o) begin
            ex_valid_q <= 1'b1;
         end else if (ex_ready_i) begin
            ex_valid_q <= 1'b0;
         end
         if (!run_i) begin
            last_taken <= 1'b0;
         end else if (src_pop_o && src_entry_i.last) begin
            last_taken <= 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (src_pop_o) begin
         ex_entry_q.last <= src_entry_i.last;
         ex_entry_q.data <= apply_op(job_i, src_entry_i.data);
      end
   end

   assign ex_valid_o = ex_valid_q;
   assign ex_entry_o = ex_entry_q;

endmodule

/* ch_fifo.sv */
//******************************
// channel FIFO
// show-ahead register FIFO with synchronous clear
// and occupancy based status flags
//******************************
`timescale 1ns/10ps

module ch_fifo (
   input  logic                  wb_clk_i,
   input  logic                  arst_n_i,
   input  logic                  clear_i,
   input  logic                  push_i,
   input  dma_ch_pkg::ch_entry_t wdata_i,
   input  logic                  pop_i,
   output dma_ch_pkg::ch_entry_t rdata_o,
   output logic                  empty_o,
   output logic                  almost_empty_o,
   output logic                  half_full_o,
   output logic                  almost_full_o,
   output logic                  full_o
);
   import dma_ch_pkg::*;

   ch_entry_t    mem [CH_FIFO_DEPTH];
   ch_fifo_ptr_t wr_ptr;
   ch_fifo_ptr_t rd_ptr;
   ch_fifo_cnt_t count;
   logic         wr_en;
   logic         rd_en;

   // a push into a full FIFO or a pop from an empty one is ignored
   assign wr_en = push_i && !full_o;
   assign rd_en = pop_i && !empty_o;

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // count only moves when exactly one side is active
         if (wr_en && !rd_en) begin
            count <= count + 1'b1;
         end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wr_en) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   // head entry is visible without a read cycle
   assign rdata_o = mem[rd_ptr];

   assign empty_o        = (count == '0);
   assign full_o         = (count == CH_FIFO_FULL);
   assign almost_empty_o = (count <= CH_FIFO_AEMPTY);
   assign almost_full_o  = (count >= CH_FIFO_AFULL);
   assign half_full_o    = (count >= CH_FIFO_HALF);

endmodule

/* ch_result.sv */
//******************************
// channel result
// pushes transformed words into the destination
// FIFO and signals job completion
//******************************
`timescale 1ns/10ps

module ch_result (
   input  logic                  wb_clk_i,
   input  logic                  arst_n_i,
   input  logic                  clear_i,
   input  logic                  ex_valid_i,
   input  dma_ch_pkg::ch_entry_t ex_entry_i,
   output logic                  ex_ready_o,
   input  logic                  dst_almost_full_i,
   output logic                  dst_push_o,
   output dma_ch_pkg::ch_entry_t dst_entry_o,
   input  logic                  dst_empty_i,
   input  logic                  dst_half_full_i,
   output logic                  job_done_o,
   output logic                  dst_start_o
);
   import dma_ch_pkg::*;

   logic finished;

   // the almost-full margin covers the entry already in flight
   assign ex_ready_o = !dst_almost_full_i || !ex_valid_i;

   assign dst_push_o  = ex_valid_i && ex_ready_o;
   assign dst_entry_o = ex_entry_i;

   // decode sees completion in the same cycle as the last push
   assign job_done_o = dst_push_o && ex_entry_i.last;

   // set when the job ends, held until the reader has drained the FIFO
   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         finished <= 1'b0;
      end else if (clear_i) begin
         finished <= 1'b0;
      end else if (job_done_o) begin
         finished <= 1'b1;
      end else if (dst_empty_i) begin
         finished <= 1'b0;
      end
   end

   // the reader is called when there is a half FIFO of data or the tail of a job
   assign dst_start_o = dst_half_full_i || (finished && !dst_empty_i);

endmodule

/* dma_ch.sv */
//******************************
// dma channel top level
// source FIFO, decode, execute, result and
// destination FIFO on one clock
//******************************
`timescale 1ns/10ps

module dma_ch (
   input  logic                 wb_clk_i,
   input  logic                 arst_n_i,
   input  logic                 clear_i,
   input  dma_ch_pkg::ch_desc_t dc_i,
   input  logic                 dc_req_i,
   output logic                 dc_ack_o,
   input  logic                 src_xfer_i,
   input  dma_ch_pkg::ch_word_t src_dat_i,
   input  logic                 src_last_i,
   output logic                 src_stop_o,
   output logic                 src_start_o,
   input  logic                 dst_xfer_i,
   output dma_ch_pkg::ch_word_t dst_dat_o,
   output logic                 dst_end_o,
   output logic                 dst_valid_o,
   output logic                 dst_stop_o,
   output logic                 dst_start_o
);
   import dma_ch_pkg::*;

   ch_entry_t src_wdata;
   ch_entry_t src_head;
   logic      src_empty;
   logic      src_half_full;
   logic      src_pop;
   ch_job_t   job;
   logic      run;
   logic      job_done;
   logic      ex_valid;
   logic      ex_ready;
   ch_entry_t ex_entry;
   logic      dst_push;
   ch_entry_t dst_wdata;
   ch_entry_t dst_head;
   logic      dst_empty;
   logic      dst_half_full;
   logic      dst_almost_full;

   assign src_wdata.last = src_last_i;
   assign src_wdata.data = src_dat_i;

   ch_fifo src_fifo (
      .wb_clk_i       (wb_clk_i),
      .arst_n_i       (arst_n_i),
      .clear_i        (clear_i),
      .push_i         (src_xfer_i),
      .wdata_i        (src_wdata),
      .pop_i          (src_pop),
      .rdata_o        (src_head),
      .empty_o        (src_empty),
      .almost_empty_o (),
      .half_full_o    (src_half_full),
      .almost_full_o  (src_stop_o),
      .full_o         ()
   );

   ch_decode u_decode (
      .wb_clk_i   (wb_clk_i),
      .arst_n_i   (arst_n_i),
      .clear_i    (clear_i),
      .dc_i       (dc_i),
      .dc_req_i   (dc_req_i),
      .dc_ack_o   (dc_ack_o),
      .job_done_i (job_done),
      .job_o      (job),
      .run_o      (run)
   );

   ch_execute u_execute (
      .wb_clk_i    (wb_clk_i),
      .arst_n_i    (arst_n_i),
      .clear_i     (clear_i),
      .run_i       (run),
      .job_i       (job),
      .src_entry_i (src_head),
      .src_empty_i (src_empty),
      .src_pop_o   (src_pop),
      .ex_ready_i  (ex_ready),
      .ex_valid_o  (ex_valid),
      .ex_entry_o  (ex_entry)
   );

   ch_result u_result (
      .wb_clk_i          (wb_clk_i),
      .arst_n_i          (arst_n_i),
      .clear_i           (clear_i),
      .ex_valid_i        (ex_valid),
      .ex_entry_i        (ex_entry),
      .ex_ready_o        (ex_ready),
      .dst_almost_full_i (dst_almost_full),
      .dst_push_o        (dst_push),
      .dst_entry_o       (dst_wdata),
      .dst_empty_i       (dst_empty),
      .dst_half_full_i   (dst_half_full),
      .job_done_o        (job_done),
      .dst_start_o       (dst_start_o)
   );

   ch_fifo dst_fifo (
      .wb_clk_i       (wb_clk_i),
      .arst_n_i       (arst_n_i),
      .clear_i        (clear_i),
      .push_i         (dst_push),
      .wdata_i        (dst_wdata),
      .pop_i          (dst_xfer_i),
      .rdata_o        (dst_head),
      .empty_o        (dst_empty),
      .almost_empty_o (),
      .half_full_o    (dst_half_full),
      .almost_full_o  (dst_almost_full),
      .full_o         ()
   );

   // source hints come straight from the source FIFO flags
   assign src_start_o = !src_half_full;

   assign dst_dat_o   = dst_head.data;
   assign dst_end_o   = dst_head.last;
   assign dst_valid_o = !dst_empty;
   assign dst_stop_o  = dst_almost_full;

endmodule

/* dma_ch_pkg.sv */
//******************************
// dma channel shared definitions
// data, descriptor and job types, the operation and
// decode state encodings, and the FIFO sizing constants
//******************************
package dma_ch_pkg;

   // FIFO geometry, both FIFOs use the same depth
   localparam int unsigned CH_FIFO_AW     = 4;
   localparam int unsigned CH_FIFO_DEPTH  = 1 << CH_FIFO_AW;
   localparam int unsigned CH_FIFO_MARGIN = 2;

   // pointer and occupancy count, the count needs one extra bit to reach full
   typedef logic [CH_FIFO_AW-1:0] ch_fifo_ptr_t;
   typedef logic [CH_FIFO_AW:0]   ch_fifo_cnt_t;

   // occupancy thresholds behind the FIFO flags
   localparam ch_fifo_cnt_t CH_FIFO_FULL   = ch_fifo_cnt_t'(CH_FIFO_DEPTH);
   localparam ch_fifo_cnt_t CH_FIFO_HALF   = ch_fifo_cnt_t'(CH_FIFO_DEPTH / 2);
   localparam ch_fifo_cnt_t CH_FIFO_AFULL  = ch_fifo_cnt_t'(CH_FIFO_DEPTH - CH_FIFO_MARGIN);
   localparam ch_fifo_cnt_t CH_FIFO_AEMPTY = ch_fifo_cnt_t'(CH_FIFO_MARGIN);

   // one stream word and the per-job operation key
   typedef logic [63:0] ch_word_t;
   typedef logic [15:0] ch_key_t;

   // word operations selected by the descriptor
   typedef enum logic [1:0] {
      OP_PASS = 2'd0,
      OP_SWAP = 2'd1,
      OP_XOR  = 2'd2,
      OP_ADD  = 2'd3
   } ch_op_e;

   // unit held in both FIFOs and passed from execute to result
   typedef struct packed {
      logic     last;
      ch_word_t data;
   } ch_entry_t;

   // host descriptor, the middle bits are reserved
   typedef struct packed {
      ch_op_e     op;
      logic [5:0] rsvd;
      ch_key_t    key;
   } ch_desc_t;

   // decoded job as seen by execute
   typedef struct packed {
      ch_op_e  op;
      ch_key_t key;
   } ch_job_t;

   // job state machine in decode
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,
      ST_ACK  = 2'd2
   } dec_state_e;

endpackage

/* tb.f */
dma_ch_pkg.sv
ch_fifo.sv
ch_decode.sv
ch_execute.sv
ch_result.sv
dma_ch.sv
tb_clk_gen.sv
tb_dma_ch.sv

/* tb_clk_gen.sv */
//******************************
// testbench clock and reset
// 100 ns clock, reset held for 10 cycles
//******************************
`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (10) @(posedge clk_o);
      arst_n_o <= 1'b1;
   end

endmodule

/* tb_dma_ch.sv */
//******************************
// dma channel testbench
// random jobs through all four operations, checked
// against a reference model at the destination stream
//******************************
`timescale 1ns/10ps

module tb_dma_ch;
   import dma_ch_pkg::*;

   logic        clk, arst_n, clear, dc_req, dc_ack;
   logic        src_xfer, src_last, src_stop, src_start;
   logic        dst_xfer, dst_end, dst_valid, dst_stop, dst_start;
   ch_desc_t    dc;
   ch_word_t    src_dat, dst_dat;
   ch_entry_t   exp_q[$];
   ch_entry_t   exp_e;
   logic        reading;
   logic [31:0] lfsr;
   int unsigned cycles, planned, sent_cnt, popped_cnt;
   int          errors, err_mark, tests_run, tests_failed;
   string       phase;
   ch_desc_t    d1, d2;
   int          n1, n2, t1, t2;

   tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

   dma_ch DUT (
      .wb_clk_i    (clk),
      .arst_n_i    (arst_n),
      .clear_i     (clear),
      .dc_i        (dc),
      .dc_req_i    (dc_req),
      .dc_ack_o    (dc_ack),
      .src_xfer_i  (src_xfer),
      .src_dat_i   (src_dat),
      .src_last_i  (src_last),
      .src_stop_o  (src_stop),
      .src_start_o (src_start),
      .dst_xfer_i  (dst_xfer),
      .dst_dat_o   (dst_dat),
      .dst_end_o   (dst_end),
      .dst_valid_o (dst_valid),
      .dst_stop_o  (dst_stop),
      .dst_start_o (dst_start)
   );

   // galois form with taps at 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   // expected output word for one input word
   function automatic ch_word_t ref_word(input ch_desc_t d, input ch_word_t w);
      ch_word_t    r;
      logic [16:0] sum;
      r = w;
      if (d.op == OP_SWAP) begin
         for (int i = 0; i < 8; i++) begin
            r[63-8*i -: 8] = w[8*i +: 8];
         end
      end else if (d.op == OP_XOR) begin
         r = w ^ {d.key, d.key, d.key, d.key};
      end else if (d.op == OP_ADD) begin
         for (int i = 0; i < 4; i++) begin
            sum = {1'b0, w[16*i +: 16]} + {1'b0, d.key};
            r[16*i +: 16] = sum[15:0];
         end
      end
      return r;
   endfunction

   function automatic ch_desc_t make_desc(input ch_op_e op);
      ch_desc_t    d;
      logic [63:0] bits;
      d.op   = op;
      bits   = rand_bits(6);
      d.rsvd = bits[5:0];
      bits   = rand_bits(16);
      d.key  = bits[15:0];
      return d;
   endfunction

   function automatic int job_len();
      return int'(rand_bits(5) % 20) + 1;
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // writes n words and marks the final one as last when last_on is set
   task automatic send_words(input ch_desc_t d, input int n, input logic last_on);
      ch_word_t  w;
      ch_entry_t e;
      for (int i = 0; i < n; i++) begin
         w = rand_bits(64);
         @(posedge clk);
         // the strobe stays low while the source FIFO asks the writer to stop
         while (src_stop) begin
            src_xfer <= 1'b0;
            @(posedge clk);
         end
         src_xfer <= 1'b1;
         src_dat  <= w;
         src_last <= last_on && (i == n - 1);
         e.last = last_on && (i == n - 1);
         e.data = ref_word(d, w);
         exp_q.push_back(e);
         sent_cnt++;
      end
      @(posedge clk);
      src_xfer <= 1'b0;
      src_last <= 1'b0;
   endtask

   task automatic handshake(input ch_desc_t d, input int unsigned target);
      @(posedge clk);
      dc     <= d;
      dc_req <= 1'b1;
      phase = "waiting for dc_ack_o to rise";
      @(posedge clk);
      while (!dc_ack) @(posedge clk);
      if (sent_cnt < target) begin
         $display("dc_ack_o rose at %0t before the job's words were all sent", $time);
         errors++;
      end
      // every word up to target is now in the destination FIFO or already read
      check_val("dst_start_o", dst_start, target != popped_cnt);
      dc_req <= 1'b0;
      phase = "waiting for dc_ack_o to fall";
      @(posedge clk);
      while (dc_ack) @(posedge clk);
   endtask

   task automatic run_job(input ch_desc_t d, input int n);
      int unsigned target;
      target = sent_cnt + n;
      planned += n;
      fork
         send_words(d, n, 1'b1);
         handshake(d, target);
      join
   endtask

   task automatic drain();
      phase = "waiting for the destination stream to drain";
      while (exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      check_val("dst_valid_o", dst_valid, 1'b0);
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (errors != err_mark) begin
         tests_failed++;
         $display("test %0d %s: FAIL", tests_run, name);
      end else begin
         $display("test %0d %s: ok", tests_run, name);
      end
      err_mark = errors;
   endtask

   // one pop per two cycles keeps every strobe inside dst_valid_o
   always @(posedge clk) begin
      dst_xfer <= reading && dst_valid && !dst_xfer;
   end

   always @(posedge clk) begin
      if (dst_xfer) begin
         popped_cnt <= popped_cnt + 1;
         if (exp_q.size() == 0) begin
            $display("word at %0t on the destination stream with none expected", $time);
            errors++;
         end else begin
            exp_e = exp_q.pop_front();
            check_val("dst_dat_o", dst_dat, exp_e.data);
            check_val("dst_end_o", dst_end, exp_e.last);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > 40 * planned + 200) begin
         $display("timeout after %0d cycles while %s", cycles, phase);
         $display("tests failed");
         $finish;
      end
   end

   initial begin
      {clear, dc_req, src_xfer, src_last, dst_xfer, reading} = '0;
      dc = '0;
      src_dat = '0;
      lfsr = 32'h2fdb;
      phase = "in reset";
      wait (arst_n === 1'b1);
      repeat (2) @(posedge clk);

      // an idle channel only invites the writer
      check_val("dc_ack_o", dc_ack, 1'b0);
      check_val("dst_valid_o", dst_valid, 1'b0);
      check_val("src_stop_o", src_stop, 1'b0);
      check_val("dst_stop_o", dst_stop, 1'b0);
      check_val("dst_start_o", dst_start, 1'b0);
      check_val("src_start_o", src_start, 1'b1);
      report_test("reset values");
      reading <= 1'b1;

      run_job(make_desc(OP_PASS), job_len());
      drain();
      report_test("pass job");

      run_job(make_desc(OP_SWAP), job_len());
      drain();
      report_test("byte swap job");

      run_job(make_desc(OP_XOR), job_len());
      run_job(make_desc(OP_ADD), job_len());
      drain();
      report_test("xor and add jobs");

      // both jobs' words go in at once and decode must keep them apart
      d1 = make_desc(OP_XOR);
      n1 = job_len();
      d2 = make_desc(OP_ADD);
      n2 = job_len();
      planned += n1 + n2;
      t1 = sent_cnt + n1;
      t2 = t1 + n2;
      fork
         begin
            send_words(d1, n1, 1'b1);
            send_words(d2, n2, 1'b1);
         end
         begin
            handshake(d1, t1);
            handshake(d2, t2);
         end
      join
      drain();
      report_test("back-to-back handshake");

      reading <= 1'b0;
      d1 = make_desc(OP_ADD);
      planned += 32;
      t1 = sent_cnt + 32;
      fork
         send_words(d1, 32, 1'b1);
         handshake(d1, t1);
         begin
            @(posedge clk);
            while (!dst_stop || !src_stop) @(posedge clk);
            if (sent_cnt >= t1) begin
               $display("writer was not held back by src_stop_o");
               errors++;
            end
            check_val("src_start_o", src_start, 1'b0);
            reading <= 1'b1;
         end
      join
      drain();
      report_test("back-pressure");

      reading <= 1'b0;
      d1 = make_desc(OP_SWAP);
      planned += 6;
      fork
         send_words(d1, 6, 1'b0);
         handshake_start: begin
            @(posedge clk);
            dc     <= d1;
            dc_req <= 1'b1;
         end
      join
      phase = "waiting for words before the clear";
      while (!dst_valid) @(posedge clk);
      clear  <= 1'b1;
      dc_req <= 1'b0;
      @(posedge clk);
      clear <= 1'b0;
      @(posedge clk);
      check_val("dst_valid_o", dst_valid, 1'b0);
      check_val("dc_ack_o", dc_ack, 1'b0);
      exp_q.delete();
      // the cleared words never reach the reader
      sent_cnt = popped_cnt;
      reading <= 1'b1;
      run_job(make_desc(OP_XOR), job_len());
      drain();
      report_test("clear mid-job");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
